//--- source/bus_pkg.sv
// Bus widths, request and response structs, handshake state type
package bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 64;
  localparam int unsigned STRB_W = DATA_W / 8;

  // Address bits that select a byte inside one bus word
  localparam int unsigned BYTE_OFF_W = $clog2(STRB_W);

  // Single access issued by the master
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] be;
  } bus_req_t;

  // Answer returned with ack
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  // Four-phase handshake sequencing
  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    ACCESS,
    ACK
  } fsm_state_t;

endpackage : bus_pkg

//--- source/soc_map_pkg.sv
// Memory map regions, base addresses, lengths, wait states and register offsets
package soc_map_pkg;

  typedef enum logic [1:0] {
    REGION_L2,
    REGION_UART,
    REGION_CTRL,
    REGION_NONE
  } region_t;

  localparam int unsigned L2_WORDS = 256;
  localparam int unsigned L2_IDX_W = $clog2(L2_WORDS);

  localparam logic [bus_pkg::ADDR_W-1:0] DRAM_BASE     = 32'h8000_0000;
  localparam logic [bus_pkg::ADDR_W-1:0] DRAM_LENGTH   = L2_WORDS * bus_pkg::STRB_W;
  localparam logic [bus_pkg::ADDR_W-1:0] UART_BASE     = 32'hC000_0000;
  localparam logic [bus_pkg::ADDR_W-1:0] CTRL_BASE     = 32'hD000_0000;
  localparam logic [bus_pkg::ADDR_W-1:0] PERIPH_LENGTH = 32'h0000_1000;

  // Wait states per region
  localparam int unsigned      WAIT_W    = 3;
  localparam logic [WAIT_W-1:0] L2_WAIT   = 3'd2;
  localparam logic [WAIT_W-1:0] UART_WAIT = 3'd4;
  localparam logic [WAIT_W-1:0] CTRL_WAIT = 3'd1;

  localparam int unsigned OFFSET_W = 12;

  // UART registers
  localparam logic [OFFSET_W-1:0] UART_THR      = 12'h000;
  localparam logic [OFFSET_W-1:0] UART_LSR      = 12'h014;
  localparam logic [7:0]          UART_LSR_IDLE = 8'h60;

  // Control registers
  localparam logic [OFFSET_W-1:0] CTRL_EXIT      = 12'h000;
  localparam logic [OFFSET_W-1:0] CTRL_DRAM_BASE = 12'h008;
  localparam logic [OFFSET_W-1:0] CTRL_DRAM_END  = 12'h010;

endpackage : soc_map_pkg

//--- source/addr_decoder.sv
// Address decoder from bus address to region and offset
module addr_decoder (
  input  logic [bus_pkg::ADDR_W-1:0]       addr_i,
  output soc_map_pkg::region_t             region_o,
  output logic [soc_map_pkg::OFFSET_W-1:0] offset_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic              hit_l2;
  logic              hit_uart;
  logic              hit_ctrl;
  logic [ADDR_W-1:0] base;
  logic [ADDR_W-1:0] rel_addr;

  assign hit_l2   = (addr_i >= DRAM_BASE) && (addr_i < DRAM_BASE + DRAM_LENGTH);
  assign hit_uart = (addr_i >= UART_BASE) && (addr_i < UART_BASE + PERIPH_LENGTH);
  assign hit_ctrl = (addr_i >= CTRL_BASE) && (addr_i < CTRL_BASE + PERIPH_LENGTH);

  always_comb begin
    region_o = REGION_NONE;
    // Unmapped accesses report offset zero
    base     = addr_i;
    if (hit_l2) begin
      region_o = REGION_L2;
      base     = DRAM_BASE;
    end else if (hit_uart) begin
      region_o = REGION_UART;
      base     = UART_BASE;
    end else if (hit_ctrl) begin
      region_o = REGION_CTRL;
      base     = CTRL_BASE;
    end
  end

  assign rel_addr = addr_i - base;
  assign offset_o = rel_addr[OFFSET_W-1:0];

  // Map windows must not overlap
  always_comb begin
    assert final ($onehot0({hit_l2, hit_uart, hit_ctrl}))
      else $error("address %h falls in more than one region", addr_i);
  end

endmodule : addr_decoder

//--- source/wait_counter.sv
// Wait-state timer loaded per region
module wait_counter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 load_i,
  input  soc_map_pkg::region_t region_i,
  output logic                 done_o
);

  import soc_map_pkg::*;

  logic [WAIT_W-1:0] cnt_q;
  logic [WAIT_W-1:0] load_val;

  always_comb begin
    case (region_i)
      REGION_L2:   load_val = L2_WAIT;
      REGION_UART: load_val = UART_WAIT;
      REGION_CTRL: load_val = CTRL_WAIT;
      default:     load_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= load_val;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign done_o = (cnt_q == '0);

  // A new access only starts once the previous wait has expired
  assert property (@(posedge clk_i) disable iff (rst_i) load_i |-> cnt_q == '0)
    else $error("wait counter reloaded while still counting");

endmodule : wait_counter

//--- source/bus_fsm.sv
// Handshake FSM with request latch, target strobes and response register
module bus_fsm (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_i,
  input  bus_pkg::bus_req_t          bus_req_i,
  output logic                       ack_o,
  output bus_pkg::bus_rsp_t          bus_rsp_o,
  input  soc_map_pkg::region_t       region_i,
  output logic                       cnt_load_o,
  input  logic                       cnt_done_i,
  output bus_pkg::bus_req_t          lat_req_o,
  output logic                       l2_stb_o,
  output logic                       uart_stb_o,
  output logic                       ctrl_stb_o,
  input  logic [bus_pkg::DATA_W-1:0] l2_rdata_i,
  input  logic [bus_pkg::DATA_W-1:0] uart_rdata_i,
  input  logic [bus_pkg::DATA_W-1:0] ctrl_rdata_i
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  fsm_state_t        state_q;
  fsm_state_t        state_d;
  bus_req_t          req_q;
  logic              err_q;
  logic              access;
  logic [DATA_W-1:0] rdata_sel;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_i) state_d = WAIT;
      WAIT:    if (cnt_done_i) state_d = ACCESS;
      ACCESS:  state_d = ACK;
      ACK:     if (!req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Decode error captured on the way into ACK
      if (access) begin
        err_q <= (region_i == REGION_NONE);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      req_q <= bus_req_i;
    end
  end

  // Transparent while idle so decoder and timer see the request on its first edge
  assign lat_req_o  = (state_q == IDLE) ? bus_req_i : req_q;
  assign cnt_load_o = (state_q == IDLE) && req_i;

  assign access     = (state_q == ACCESS);
  assign l2_stb_o   = access && (region_i == REGION_L2);
  assign uart_stb_o = access && (region_i == REGION_UART);
  assign ctrl_stb_o = access && (region_i == REGION_CTRL);

  // Target read data stays registered until its next strobe
  always_comb begin
    case (region_i)
      REGION_L2:   rdata_sel = l2_rdata_i;
      REGION_UART: rdata_sel = uart_rdata_i;
      REGION_CTRL: rdata_sel = ctrl_rdata_i;
      default:     rdata_sel = '0;
    endcase
  end

  assign ack_o           = (state_q == ACK);
  assign bus_rsp_o.rdata = rdata_sel;
  assign bus_rsp_o.err   = err_q;

  assert property (@(posedge clk_i) disable iff (rst_i)
    (req_i && !ack_o) ##1 req_i |-> $stable(bus_req_i))
    else $error("request changed before acknowledge");

  assert property (@(posedge clk_i) disable iff (rst_i) $rose(ack_o) |-> $past(req_i))
    else $error("acknowledge raised without a pending request");

endmodule : bus_fsm

//--- source/l2_mem.sv
// Byte-enabled synchronous L2 memory for the DRAM window
module l2_mem (
  input  logic                             clk_i,
  input  logic                             stb_i,
  input  bus_pkg::bus_req_t                req_i,
  input  logic [soc_map_pkg::OFFSET_W-1:0] offset_i,
  output logic [bus_pkg::DATA_W-1:0]       rdata_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic [DATA_W-1:0]   mem_q [L2_WORDS];
  logic [L2_IDX_W-1:0] idx;

  // Word index with the byte lane bits dropped
  assign idx = offset_i[L2_IDX_W+BYTE_OFF_W-1:BYTE_OFF_W];

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      if (req_i.we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (req_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        rdata_o <= '0;
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

endmodule : l2_mem

//--- source/uart_mock.sv
// Mock UART with transmit holding and line status registers
module uart_mock (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             stb_i,
  input  bus_pkg::bus_req_t                req_i,
  input  logic [soc_map_pkg::OFFSET_W-1:0] offset_i,
  output logic [bus_pkg::DATA_W-1:0]       rdata_o,
  output logic [7:0]                       uart_char_o,
  output logic                             uart_valid_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic thr_wr;
  logic lsr_rd;

  assign thr_wr = stb_i && req_i.we && (offset_i == UART_THR);
  assign lsr_rd = !req_i.we && (offset_i == UART_LSR);

  // One-cycle pulse per transmitted character
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      uart_valid_o <= 1'b0;
    end else begin
      uart_valid_o <= thr_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (thr_wr) begin
      uart_char_o <= req_i.wdata[7:0];
    end
  end

  // Transmitter always reports empty and idle
  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      if (lsr_rd) begin
        rdata_o <= {{(DATA_W-8){1'b0}}, UART_LSR_IDLE};
      end else begin
        rdata_o <= '0;
      end
    end
  end

endmodule : uart_mock

//--- source/ctrl_regs.sv
// Control registers with exit code and read-only DRAM window
module ctrl_regs (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             stb_i,
  input  bus_pkg::bus_req_t                req_i,
  input  logic [soc_map_pkg::OFFSET_W-1:0] offset_i,
  output logic [bus_pkg::DATA_W-1:0]       rdata_o,
  output logic [bus_pkg::DATA_W-1:0]       exit_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic              exit_wr;
  logic [DATA_W-1:0] rd_val;

  assign exit_wr = stb_i && req_i.we && (offset_i == CTRL_EXIT);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_o <= '0;
    end else if (exit_wr) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req_i.be[b]) begin
          exit_o[8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // DRAM window registers are constants, writes fall through
  always_comb begin
    case (offset_i)
      CTRL_EXIT:      rd_val = exit_o;
      CTRL_DRAM_BASE: rd_val = DATA_W'(DRAM_BASE);
      CTRL_DRAM_END:  rd_val = DATA_W'(DRAM_BASE) + DATA_W'(DRAM_LENGTH);
      default:        rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      rdata_o <= req_i.we ? '0 : rd_val;
    end
  end

endmodule : ctrl_regs

//--- source/soc_harness.sv
// Top level of the test-harness fabric with decoder, timer, FSM and targets
module soc_harness (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_i,
  input  bus_pkg::bus_req_t          bus_req_i,
  output logic                       ack_o,
  output bus_pkg::bus_rsp_t          bus_rsp_o,
  output logic [7:0]                 uart_char_o,
  output logic                       uart_valid_o,
  output logic [bus_pkg::DATA_W-1:0] exit_o
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  bus_req_t            lat_req;
  region_t             region;
  logic [OFFSET_W-1:0] offset;
  logic                cnt_load;
  logic                cnt_done;
  logic                l2_stb;
  logic                uart_stb;
  logic                ctrl_stb;
  logic [DATA_W-1:0]   l2_rdata;
  logic [DATA_W-1:0]   uart_rdata;
  logic [DATA_W-1:0]   ctrl_rdata;

  addr_decoder i_addr_decoder (
    .addr_i  (lat_req.addr),
    .region_o(region      ),
    .offset_o(offset      )
  );

  wait_counter i_wait_counter (
    .clk_i   (clk_i   ),
    .rst_i   (rst_i   ),
    .load_i  (cnt_load),
    .region_i(region  ),
    .done_o  (cnt_done)
  );

  bus_fsm i_bus_fsm (
    .clk_i       (clk_i     ),
    .rst_i       (rst_i     ),
    .req_i       (req_i     ),
    .bus_req_i   (bus_req_i ),
    .ack_o       (ack_o     ),
    .bus_rsp_o   (bus_rsp_o ),
    .region_i    (region    ),
    .cnt_load_o  (cnt_load  ),
    .cnt_done_i  (cnt_done  ),
    .lat_req_o   (lat_req   ),
    .l2_stb_o    (l2_stb    ),
    .uart_stb_o  (uart_stb  ),
    .ctrl_stb_o  (ctrl_stb  ),
    .l2_rdata_i  (l2_rdata  ),
    .uart_rdata_i(uart_rdata),
    .ctrl_rdata_i(ctrl_rdata)
  );

  l2_mem i_l2_mem (
    .clk_i   (clk_i   ),
    .stb_i   (l2_stb  ),
    .req_i   (lat_req ),
    .offset_i(offset  ),
    .rdata_o (l2_rdata)
  );

  uart_mock i_uart_mock (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .stb_i       (uart_stb    ),
    .req_i       (lat_req     ),
    .offset_i    (offset      ),
    .rdata_o     (uart_rdata  ),
    .uart_char_o (uart_char_o ),
    .uart_valid_o(uart_valid_o)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i   (clk_i     ),
    .rst_i   (rst_i     ),
    .stb_i   (ctrl_stb  ),
    .req_i   (lat_req   ),
    .offset_i(offset    ),
    .rdata_o (ctrl_rdata),
    .exit_o  (exit_o    )
  );

endmodule : soc_harness

//--- sim/tb_stim_table.svh
// Directed stimulus entries with columns we, addr, wdata, be, expected rdata, expected err
`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

typedef struct packed {
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] be;
  logic [DATA_W-1:0] exp_rdata;
  logic              exp_err;
} stim_t;

localparam int STIM_N = 24;

stim_t stim_table [STIM_N] = '{
  // L2 words built up under partial byte enables
  '{1'b1, 32'h8000_0040, 64'h0123_4567_89AB_CDEF, 8'hFF, 64'h0, 1'b0},
  '{1'b1, 32'h8000_0040, 64'hFFEE_DDCC_BBAA_9988, 8'h0F, 64'h0, 1'b0},
  '{1'b1, 32'h8000_0040, 64'h5555_5555_5555_5555, 8'hA0, 64'h0, 1'b0},
  '{1'b0, 32'h8000_0040, 64'h0, 8'hFF, 64'h5523_5567_BBAA_9988, 1'b0},
  '{1'b1, 32'h8000_07F8, 64'hDEAD_BEEF_CAFE_F00D, 8'hFF, 64'h0, 1'b0},
  '{1'b1, 32'h8000_07F8, 64'h0000_0000_0000_1234, 8'h03, 64'h0, 1'b0},
  '{1'b0, 32'h8000_07F8, 64'h0, 8'hFF, 64'hDEAD_BEEF_CAFE_1234, 1'b0},
  // UART transmit and status
  '{1'b1, 32'hC000_0000, 64'h0000_0000_0000_0141, 8'hFF, 64'h0, 1'b0},
  '{1'b0, 32'hC000_0014, 64'h0, 8'hFF, 64'h0000_0000_0000_0060, 1'b0},
  '{1'b1, 32'hC000_0000, 64'h1111_2222_3333_445A, 8'h01, 64'h0, 1'b0},
  '{1'b0, 32'hC000_0008, 64'h0, 8'hFF, 64'h0, 1'b0},
  // Exit code and DRAM window registers
  '{1'b1, 32'hD000_0000, 64'h1122_3344_5566_7788, 8'hFF, 64'h0, 1'b0},
  '{1'b1, 32'hD000_0000, 64'h0, 8'hF0, 64'h0, 1'b0},
  '{1'b0, 32'hD000_0000, 64'h0, 8'hFF, 64'h0000_0000_5566_7788, 1'b0},
  '{1'b0, 32'hD000_0008, 64'h0, 8'hFF, 64'h0000_0000_8000_0000, 1'b0},
  '{1'b1, 32'hD000_0008, 64'hFFFF_FFFF_FFFF_FFFF, 8'hFF, 64'h0, 1'b0},
  '{1'b0, 32'hD000_0008, 64'h0, 8'hFF, 64'h0000_0000_8000_0000, 1'b0},
  '{1'b1, 32'hD000_0010, 64'h0, 8'hFF, 64'h0, 1'b0},
  '{1'b0, 32'hD000_0010, 64'h0, 8'hFF, 64'h0000_0000_8000_0800, 1'b0},
  // Just outside the windows, would alias L2 word 0 or the exit register
  '{1'b1, 32'h8000_0800, 64'hFFFF_FFFF_FFFF_FFFF, 8'hFF, 64'h0, 1'b1},
  '{1'b1, 32'hD000_1000, 64'hFFFF_FFFF_FFFF_FFFF, 8'hFF, 64'h0, 1'b1},
  '{1'b0, 32'hC000_1000, 64'h0, 8'hFF, 64'h0, 1'b1},
  '{1'b0, 32'h0000_0000, 64'h0, 8'hFF, 64'h0, 1'b1},
  '{1'b0, 32'hD000_0000, 64'h0, 8'hFF, 64'h0000_0000_5566_7788, 1'b0}
};

`endif

//--- sim/tb_soc_harness.sv
// Testbench for the fabric with clock, reset, handshake driver, reference model and checks
module tb_soc_harness;

  timeunit 1ns;
  timeprecision 1ps;

  import bus_pkg::*;
  import soc_map_pkg::*;

  `include "tb_stim_table.svh"

  localparam int ACK_TIMEOUT = 50;
  localparam int CHK_W       = DATA_W + 1;
  localparam int N_RANDOM    = 48;

  logic              clk_i = 1'b0;
  logic              rst_i;
  logic              req_i;
  bus_req_t          bus_req_i;
  logic              ack_o;
  bus_rsp_t          bus_rsp_o;
  logic [7:0]        uart_char_o;
  logic              uart_valid_o;
  logic [DATA_W-1:0] exit_o;

  // Reference model
  logic [DATA_W-1:0] ref_mem [L2_WORDS];
  logic [DATA_W-1:0] ref_exit;
  int                exp_pulses;
  logic [7:0]        exp_char;

  int                uart_pulses = 0;
  logic [7:0]        seen_char;
  integer            seed;

  soc_harness i_soc_harness (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .req_i       (req_i       ),
    .bus_req_i   (bus_req_i   ),
    .ack_o       (ack_o       ),
    .bus_rsp_o   (bus_rsp_o   ),
    .uart_char_o (uart_char_o ),
    .uart_valid_o(uart_valid_o),
    .exit_o      (exit_o      )
  );

  always #50 clk_i = ~clk_i;

  // Count transmitted characters mid-cycle
  always @(negedge clk_i) begin
    if (uart_valid_o === 1'b1) begin
      uart_pulses++;
      seen_char = uart_char_o;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [CHK_W-1:0] actual,
                             input logic [CHK_W-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                          $time, name, actual, expected));
    end
  endtask

  function automatic region_t region_of(input logic [ADDR_W-1:0] addr);
    if (addr >= DRAM_BASE && addr < DRAM_BASE + DRAM_LENGTH) return REGION_L2;
    if (addr >= UART_BASE && addr < UART_BASE + PERIPH_LENGTH) return REGION_UART;
    if (addr >= CTRL_BASE && addr < CTRL_BASE + PERIPH_LENGTH) return REGION_CTRL;
    return REGION_NONE;
  endfunction

  function automatic int wait_states(input logic [ADDR_W-1:0] addr);
    case (region_of(addr))
      REGION_L2:   return int'(L2_WAIT);
      REGION_UART: return int'(UART_WAIT);
      REGION_CTRL: return int'(CTRL_WAIT);
      default:     return 0;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_val,
                                                    input logic [DATA_W-1:0] wdata,
                                                    input logic [STRB_W-1:0] be);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < STRB_W; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  task automatic model_update(input bus_req_t req);
    logic [L2_IDX_W-1:0] idx;
    logic [OFFSET_W-1:0] off;
    idx = req.addr[L2_IDX_W+BYTE_OFF_W-1:BYTE_OFF_W];
    off = req.addr[OFFSET_W-1:0];
    if (req.we) begin
      case (region_of(req.addr))
        REGION_L2: ref_mem[idx] = merge_bytes(ref_mem[idx], req.wdata, req.be);
        REGION_UART: begin
          if (off == UART_THR) begin
            exp_pulses++;
            exp_char = req.wdata[7:0];
          end
        end
        REGION_CTRL: begin
          if (off == CTRL_EXIT) ref_exit = merge_bytes(ref_exit, req.wdata, req.be);
        end
        default: ;
      endcase
    end
  endtask

  // One four-phase access, entered and left 5 ns after a rising edge
  task automatic run_access(input bus_req_t req, input bus_rsp_t exp_rsp);
    int          cycles;
    int          hold;
    logic [31:0] rnd;
    bus_rsp_t    held;
    rnd  = $random(seed);
    hold = int'(rnd[2:0]);
    model_update(req);
    bus_req_i = req;
    req_i     = 1'b1;
    cycles    = 0;
    while (ack_o !== 1'b1) begin
      if (cycles == ACK_TIMEOUT) begin
        abort_run($sformatf("Timed out waiting for ack_o on address %h", req.addr));
      end
      @(posedge clk_i);
      #5;
      cycles++;
    end
    // Cycle 1 is the edge that first samples req_i high
    check_value("ack_o latency", CHK_W'(cycles - 1), CHK_W'(wait_states(req.addr) + 2));
    check_value("bus_rsp_o.rdata", CHK_W'(bus_rsp_o.rdata), CHK_W'(exp_rsp.rdata));
    check_value("bus_rsp_o.err", CHK_W'(bus_rsp_o.err), CHK_W'(exp_rsp.err));
    held = bus_rsp_o;
    repeat (hold) begin
      @(posedge clk_i);
      #5;
      check_value("ack_o", CHK_W'(ack_o), CHK_W'(1'b1));
      check_value("bus_rsp_o", CHK_W'(bus_rsp_o), CHK_W'(held));
    end
    req_i  = 1'b0;
    cycles = 0;
    while (ack_o !== 1'b0) begin
      if (cycles == ACK_TIMEOUT) begin
        abort_run($sformatf("Timed out waiting for ack_o to fall on address %h", req.addr));
      end
      @(posedge clk_i);
      #5;
      cycles++;
    end
    check_value("ack_o fall delay", CHK_W'(cycles), CHK_W'(1));
    check_value("exit_o", CHK_W'(exit_o), CHK_W'(ref_exit));
    check_value("uart_valid_o pulses", CHK_W'(uart_pulses), CHK_W'(exp_pulses));
    if (exp_pulses > 0) begin
      check_value("uart_char_o", CHK_W'(seen_char), CHK_W'(exp_char));
    end
  endtask

  initial begin
    bus_req_t    req;
    bus_rsp_t    exp_rsp;
    logic [31:0] rnd;
    seed       = 97115;
    rst_i      = 1'b1;
    req_i      = 1'b0;
    bus_req_i  = '0;
    ref_exit   = '0;
    exp_pulses = 0;
    exp_char   = '0;
    repeat (4) @(posedge clk_i);
    #5;
    rst_i = 1'b0;
    check_value("ack_o", CHK_W'(ack_o), '0);
    check_value("uart_valid_o", CHK_W'(uart_valid_o), '0);
    check_value("exit_o", CHK_W'(exit_o), '0);

    // Fill every L2 word with a pattern made from its address
    for (int i = 0; i < L2_WORDS; i++) begin
      req.we    = 1'b1;
      req.addr  = DRAM_BASE + ADDR_W'(i * STRB_W);
      req.wdata = {~req.addr, req.addr};
      req.be    = '1;
      run_access(req, '0);
    end

    foreach (stim_table[i]) begin
      req.we        = stim_table[i].we;
      req.addr      = stim_table[i].addr;
      req.wdata     = stim_table[i].wdata;
      req.be        = stim_table[i].be;
      exp_rsp.rdata = stim_table[i].exp_rdata;
      exp_rsp.err   = stim_table[i].exp_err;
      run_access(req, exp_rsp);
    end

    // Random partial writes and reads inside the DRAM window
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd       = $random(seed);
      req.we    = 1'b1;
      req.addr  = DRAM_BASE + ADDR_W'({rnd[7:0], 3'b000});
      req.wdata = {$random(seed), $random(seed)};
      req.be    = rnd[15:8];
      run_access(req, '0);
      rnd           = $random(seed);
      req.we        = 1'b0;
      req.addr      = DRAM_BASE + ADDR_W'({rnd[7:0], 3'b000});
      req.be        = '1;
      exp_rsp.rdata = ref_mem[rnd[7:0]];
      exp_rsp.err   = 1'b0;
      run_access(req, exp_rsp);
    end

    // Whole L2 read back, catches stray writes from unmapped accesses
    for (int i = 0; i < L2_WORDS; i++) begin
      req.we        = 1'b0;
      req.addr      = DRAM_BASE + ADDR_W'(i * STRB_W);
      req.wdata     = '0;
      req.be        = '1;
      exp_rsp.rdata = ref_mem[i];
      exp_rsp.err   = 1'b0;
      run_access(req, exp_rsp);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule : tb_soc_harness

//--- sim.f
+incdir+sim
source/bus_pkg.sv
source/soc_map_pkg.sv
source/addr_decoder.sv
source/wait_counter.sv
source/bus_fsm.sv
source/l2_mem.sv
source/uart_mock.sv
source/ctrl_regs.sv
source/soc_harness.sv
sim/tb_soc_harness.sv
